// File: Bender.yml
package:
  name: exStage

sources:
  - src/exPkg.sv
  - src/memPkg.sv
  - src/exCtrl.sv
  - src/exAlu.sv
  - src/exMul.sv
  - src/exMemPort.sv
  - src/exWriteback.sv
  - src/exStageTop.sv
  - target: test
    files:
      - bench/exStageTb.sv

// File: all.f
src/exPkg.sv
src/memPkg.sv
src/exCtrl.sv
src/exAlu.sv
src/exMul.sv
src/exMemPort.sv
src/exWriteback.sv
src/exStageTop.sv
bench/exStageTb.sv

// File: bench/exStageTb.sv
// Run from the project root; memory model is 128 words on addr[9:3], load results are checked against its prediction
`timescale 1ns/100ps
`default_nettype none

module exStageTb
	import exPkg::*, memPkg::*;
();

	localparam int mulLatency  = 3;
	localparam int resetCycles = 10;
	localparam int maxTests    = 64;

	typedef struct packed {
		exUop_t      uop;
		logic        flush;	// Kill the op while in EX1
		logic [3:0]  waits;	// memHold answers before the final status
		logic        faultIn;	// Final status is memFault
		logic        expValid;
		logic [63:0] expValue;	// Unused for loads
		logic [1:0]  expSr;
		logic [63:0] expDlr;
		logic [63:0] expDhr;
		logic        expFault;
	} testVec_t;

	logic        clock;
	logic        rstN;
	exUop_t      issue;
	logic        flush;
	logic        exHold;
	exWb_t       wb;
	logic [1:0]  sr;
	logic [63:0] dlr;
	logic [63:0] dhr;
	memReq_t     memReq;
	memResp_t    memResp;
	logic        fault;

	testVec_t    vecs[maxTests];
	string       names[maxTests];
	logic [63:0] mem[128];	// Model memory, written through memReq
	logic [63:0] refMem[128];	// Predicted contents
	int          testCount = 0;
	int          failCount = 0;
	int          checkErrs;	// Failed checks in the running test
	int          cycles = 0;
	int          cycleLimit = 0;
	string       curName;
	logic        tRef;	// T left by the previous test

	exStageTop #(.mulLatency(mulLatency)) i_exStageTop (
		.clock(clock), .rstN(rstN), .issue(issue), .flush(flush), .exHold(exHold),
		.wb(wb), .sr(sr), .dlr(dlr), .dhr(dhr), .memReq(memReq), .memResp(memResp),
		.fault(fault)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = !clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Store completes on memOk
	always @(posedge clock) begin
		if (memReq.valid && memReq.write && memResp.status == memOk) begin
			mem[memReq.addr[9:3]] <= memReq.data;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic predicateMet(input pred_t pred);
		case (pred)
			predAlways: return 1'b1;
			predNever:  return 1'b0;
			predIfTrue: return tRef;
			default:    return !tRef;
		endcase
	endfunction

	function automatic memStatus_t respStatus(input int left, input logic faultIn);
		if (left > 0) return memHold;
		else if (faultIn) return memFault;
		else return memOk;
	endfunction

	task automatic compareValue(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("** Error %s %s: expected %h, actual %h", curName, what, expected, actual);
			checkErrs++;
		end
	endtask

	task automatic readTests();
		int          fd;
		int          code;
		string       word;
		string       rest;
		logic [63:0] col[16];
		testVec_t    v;
		fd = $fopen("bench/exStageTests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/exStageTests.txt, no tests to run");
			failCount++;
			return;
		end
		while ($fscanf(fd, "%s", word) == 1 && testCount < maxTests) begin
			if (word.getc(0) == "#") begin
				code = $fgets(rest, fd);	// Column notes
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
				if (code != 16) begin
					$display("Test line %s is malformed and was dropped", word);
					failCount++;
				end else begin
					v.uop.valid   = 1'b1;
					v.uop.cmd     = uCmd_t'(col[0][3:0]);
					v.uop.pred    = pred_t'(col[1][1:0]);
					v.uop.mulMode = mulMode_t'(col[2][1:0]);
					v.uop.rd      = col[3][5:0];
					v.uop.srcA    = col[4];
					v.uop.srcB    = col[5];
					v.uop.srcC    = col[6];
					v.flush       = col[7][0];
					v.waits       = col[8][3:0];
					v.faultIn     = col[9][0];
					v.expValid    = col[10][0];
					v.expValue    = col[11];
					v.expSr       = col[12][1:0];
					v.expDlr      = col[13];
					v.expDhr      = col[14];
					v.expFault    = col[15][0];
					names[testCount] = word;
					vecs[testCount]  = v;
					testCount++;
				end
			end
		end
		$fclose(fd);
		if (testCount == 0) begin
			$display("No test lines found in bench/exStageTests.txt");
			failCount++;
		end
	endtask

	// One op through an empty pipe, checked one edge after it leaves EX2
	task automatic runTest(input testVec_t v);
		int          left;
		int          holds;
		int          expHolds;
		int          idx;
		logic        enabled;
		logic        isMem;
		logic [31:0] addr;
		left    = v.waits;
		holds   = 0;
		enabled = v.uop.valid && !v.flush && predicateMet(v.uop.pred);
		isMem   = v.uop.cmd == cmdLoad || v.uop.cmd == cmdStore;
		addr    = v.uop.srcA[31:0] + v.uop.srcB[31:0];
		idx     = addr[9:3];
		if (enabled && v.uop.cmd == cmdMul) expHolds = mulLatency - 1;
		else if (enabled && isMem) expHolds = v.waits;
		else expHolds = 0;
		@(posedge clock);
		issue <= v.uop;
		@(posedge clock);
		issue <= '0;
		flush <= v.flush;	// Op sits in EX1 this cycle
		@(posedge clock);
		flush          <= 1'b0;
		memResp.status <= respStatus(left, v.faultIn);
		memResp.data   <= mem[idx];
		@(negedge clock);
		compareValue("memReq.valid", enabled && isMem, memReq.valid);
		if (enabled && isMem) begin
			compareValue("memReq.write", v.uop.cmd == cmdStore, memReq.write);
			compareValue("memReq.addr", addr, memReq.addr);
			if (v.uop.cmd == cmdStore) compareValue("memReq.data", v.uop.srcC, memReq.data);
		end
		while (exHold) begin
			holds++;
			@(posedge clock);
			if (left > 0) left--;
			memResp.status <= respStatus(left, v.faultIn);
			memResp.data   <= mem[idx];
			@(negedge clock);
			if (enabled && isMem) compareValue("memReq.addr", addr, memReq.addr);	// Held stable
		end
		@(posedge clock);	// Retire edge
		memResp.status <= memOk;
		memResp.data   <= '0;
		@(negedge clock);
		compareValue("wb.valid", v.expValid, wb.valid);
		if (v.expValid) begin
			compareValue("wb.rd", v.uop.rd, wb.rd);
			compareValue("wb.value", v.uop.cmd == cmdLoad ? refMem[idx] : v.expValue, wb.value);
		end
		compareValue("sr", v.expSr, sr);
		compareValue("dlr", v.expDlr, dlr);
		compareValue("dhr", v.expDhr, dhr);
		compareValue("fault", v.expFault, fault);
		compareValue("hold cycles", expHolds, holds);
		if (enabled && v.uop.cmd == cmdStore && !v.faultIn) refMem[idx] = v.uop.srcC;
		tRef = v.expSr[0];
	endtask

	// Unpredicated ALU lines issued back to back, one retire per cycle
	task automatic runBurst();
		testVec_t burst[$];
		int       n;
		for (int i = 0; i < testCount; i++) begin
			if (vecs[i].uop.cmd >= cmdAdd && vecs[i].uop.cmd <= cmdXor &&
					vecs[i].uop.pred == predAlways && !vecs[i].flush) begin
				burst.push_back(vecs[i]);
			end
		end
		n = burst.size();
		for (int j = 0; j < n + 3; j++) begin
			@(posedge clock);
			if (j < n) issue <= burst[j].uop;
			else issue <= '0;
			@(negedge clock);
			compareValue("exHold", 0, exHold);
			if (j >= 3) begin	// Op j-3 written back at this edge
				compareValue("wb.valid", 1, wb.valid);
				compareValue("wb.rd", burst[j-3].uop.rd, wb.rd);
				compareValue("wb.value", burst[j-3].expValue, wb.value);
			end
		end
	endtask

	initial begin
		logic [31:0] state;
		int          maxWait;
		rstN           = 1'b0;
		issue          = '0;
		flush          = 1'b0;
		memResp.status = memOk;
		memResp.data   = '0;
		tRef           = 1'b0;
		maxWait        = 0;
		state          = 32'h37a8f76d;
		for (int i = 0; i < 128; i++) begin
			state          = xorshift(state);
			mem[i][63:32]  = state;
			state          = xorshift(state);
			mem[i][31:0]   = state;
			refMem[i]      = mem[i];
		end
		readTests();
		for (int i = 0; i < testCount; i++) begin
			if (vecs[i].waits > maxWait) maxWait = vecs[i].waits;
		end
		cycleLimit = (testCount + 1) * (mulLatency + maxWait + 4) + resetCycles;	// Burst counts as one
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;
		for (int i = 0; i < testCount; i++) begin
			curName   = names[i];
			checkErrs = 0;
			runTest(vecs[i]);
			$display("%-4s %s", checkErrs == 0 ? "ok" : "FAIL", curName);
			if (checkErrs != 0) failCount++;
		end
		curName   = "burstAlu";
		checkErrs = 0;
		runBurst();
		$display("%-4s %s", checkErrs == 0 ? "ok" : "FAIL", curName);
		if (checkErrs != 0) failCount++;
		$display("%0d tests run, %0d failed", testCount + 1, failCount);
		if (failCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/exStageTests.txt
# name cmd pred mode rd srcA srcB srcC flush waits fault expValid expValue expSr expDlr expDhr expFault
# cmd 1 add 2 sub 3 and 4 or 5 xor 6 cmpEq 7 cmpGt 8 mul 9 load a store; pred 0 always 1 never 2 ifT 3 ifF
addCarry 1 0 0 01 ffffffffffffffff 2 0 0 0 0 1 1 2 0 0 0
subBorrow 2 0 0 02 5 7 0 0 0 0 1 fffffffffffffffe 2 0 0 0
subNoBorrow 2 0 0 03 10 3 0 0 0 0 1 d 0 0 0 0
andOp 3 0 0 04 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 0 0 1 0f000f000f000f00 0 0 0 0
orOp 4 0 0 05 f0 0f 0 0 0 0 1 ff 0 0 0 0
xorOp 5 0 0 06 aaaa ffff 0 0 0 0 1 5555 0 0 0 0
cmpEqTrue 6 0 0 07 1234 1234 0 0 0 0 0 0 1 0 0 0
predTrueRun 1 2 0 08 1 2 0 0 0 0 1 3 1 0 0 0
predFalseSkip 1 3 0 09 1 2 0 0 0 0 0 0 1 0 0 0
cmpGtFalse 7 0 0 0a ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0
predFalseRun 5 3 0 0b f 3 0 0 0 0 1 c 0 0 0 0
cmpGtTrue 7 0 0 0c 5 ffffffffffffffff 0 0 0 0 0 0 1 0 0 0
neverOp 1 1 0 0d ffffffffffffffff 1 0 0 0 0 0 0 1 0 0 0
flushedOp 6 0 0 0e 1 2 0 1 0 0 0 0 1 0 0 0
mulLowS 8 0 0 0f fffffffe 3 0 0 0 0 1 fffffffffffffffa 1 0 0 0
mulLowU 8 0 1 10 fffffffe 3 0 0 0 0 1 fffffffa 1 0 0 0
mulWideS 8 0 2 11 fffffffe 3 0 0 0 0 0 0 1 fffffffa ffffffffffffffff 0
mulWideU 8 0 3 12 80000000 4 0 0 0 0 0 0 1 0 2 0
storeA a 0 0 00 100 8 1122334455667788 0 3 0 0 0 1 0 2 0
loadBack 9 0 0 13 100 8 0 0 5 0 1 0 1 0 2 0
loadFill 9 0 0 14 200 0 0 0 0 0 1 0 1 0 2 0
storeFault a 0 0 00 100 8 dead 0 2 1 0 0 1 0 2 1
loadAfterFault 9 0 0 15 108 0 0 0 1 0 1 0 1 0 2 1
loadFault 9 0 0 16 300 0 0 0 0 1 0 0 1 0 2 1
addAfter 1 0 0 17 7 8 0 0 0 0 1 f 1 0 2 1

// File: src/exAlu.sv
// Combinational 64-bit ALU; SUB carry is a borrow, logic ops clear carry, value is a for compares
`timescale 1ns/100ps
`default_nettype none

module exAlu
	import exPkg::*;
(
	input  wire [63:0] a,
	input  wire [63:0] b,
	input  wire uCmd_t cmd,
	input  wire        carryIn,
	output aluRes_t    res
);

	logic [64:0] sum;	// Carry out in bit 64
	logic [64:0] diff;	// Borrow out in bit 64
	logic        isEq;
	logic        isGt;

	assign sum  = {1'b0, a} + {1'b0, b} + {64'd0, carryIn};
	assign diff = {1'b0, a} - {1'b0, b} - {64'd0, carryIn};
	assign isEq = a == b;
	assign isGt = $signed(a) > $signed(b);

	always_comb begin
		res.value = a;	// Passed through for compares
		res.carry = 1'b0;
		res.tFlag = 1'b0;
		case (cmd)
			cmdAdd: begin
				res.value = sum[63:0];
				res.carry = sum[64];
			end
			cmdSub: begin
				res.value = diff[63:0];
				res.carry = diff[64];
			end
			cmdAnd: res.value = a & b;
			cmdOr:  res.value = a | b;
			cmdXor: res.value = a ^ b;
			cmdCmpEq: res.tFlag = isEq;
			cmdCmpGt: res.tFlag = isGt;
			default: begin
				// MUL and memory ops use other paths
				res.value = a;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/exCtrl.sv
// EX2 control for one op at a time; mulLatency of 1 gives no multiply hold, fault clears only on reset
`timescale 1ns/100ps
`default_nettype none

module exCtrl
	import exPkg::*, memPkg::*;
#(
	parameter int mulLatency = 3
) (
	input  wire        clock,
	input  wire        rstN,
	input  wire exUop_t ex2Op,
	input  wire        tBit,
	input  wire memStatus_t memStatus,
	output logic       opEnable,
	output logic [1:0] wbSel,
	output logic       exHold,
	output logic       fault
);

	localparam int cntW = $clog2(mulLatency + 1);
	localparam logic [cntW-1:0] mulHoldCycles = cntW'(mulLatency - 1);

	logic            predOk;
	logic            isMul;
	logic            isMem;
	logic            mulHold;
	logic            memWait;
	logic [cntW-1:0] holdCnt;	// Cycles a MUL has held so far

	// Predicate against T as left by the last retired op
	always_comb begin
		case (ex2Op.pred)
			predAlways: predOk = 1'b1;
			predNever:  predOk = 1'b0;
			predIfTrue: predOk = tBit;
			default:    predOk = !tBit;	// predIfFalse
		endcase
	end

	assign opEnable = ex2Op.valid && predOk;
	assign isMul    = ex2Op.cmd == cmdMul;
	assign isMem    = ex2Op.cmd inside {cmdLoad, cmdStore};

	// Hold until the product has walked the multiplier
	assign mulHold = opEnable && isMul && (holdCnt != mulHoldCycles);
	assign memWait = opEnable && isMem && (memStatus == memHold);	// Access not done
	assign exHold  = mulHold || memWait;

	// Writeback source
	always_comb begin
		case (ex2Op.cmd)
			cmdAdd, cmdSub, cmdAnd, cmdOr, cmdXor: wbSel = wbAlu;
			cmdMul:  wbSel = wbMul;
			cmdLoad: wbSel = wbLoad;
			default: wbSel = wbCmp;	// Compares; NOP and STORE never retire with effect
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			holdCnt <= '0;
		end else if (mulHold) begin
			holdCnt <= holdCnt + 1'b1;
		end else begin
			holdCnt <= '0;	// Ready for the next MUL
		end
	end

	// Sticky memory fault
	always_ff @(posedge clock) begin
		if (!rstN) begin
			fault <= 1'b0;
		end else if (opEnable && isMem && memStatus == memFault) begin
			fault <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/exMemPort.sv
// Data memory port for the EX2 op; one access at a time, request held stable by the EX2 registers
`timescale 1ns/100ps
`default_nettype none

module exMemPort
	import exPkg::*, memPkg::*;
(
	input  wire        clock,
	input  wire        rstN,
	input  wire exUop_t ex2Op,
	input  wire        opEnable,
	input  wire [31:0] addr,
	output memReq_t    memReq,
	input  wire memResp_t memResp,
	output logic [63:0] loadData
);

	logic isLoad;
	logic isStore;
	logic capture;

	assign isLoad  = ex2Op.cmd == cmdLoad;
	assign isStore = ex2Op.cmd == cmdStore;

	// Request lives as long as the op sits in EX2
	always_comb begin
		memReq.valid = opEnable && (isLoad || isStore);
		memReq.write = isStore;
		memReq.addr  = addr;	// Formed in EX1
		memReq.data  = ex2Op.srcC;
	end

	// Take load data on the completing cycle only
	assign capture = memReq.valid && isLoad && memResp.status == memOk;

	// Lines up with the writeback registers at the retire edge
	always_ff @(posedge clock) begin
		if (!rstN) begin
			loadData <= '0;
		end else if (capture) begin
			loadData <= memResp.data;
		end
	end

endmodule

`default_nettype wire

// File: src/exMul.sv
// 32x32 multiplier with mulLatency register stages; product is valid mulLatency advancing edges after its operands
`timescale 1ns/100ps
`default_nettype none

module exMul #(
	parameter int mulLatency = 3
) (
	input  wire        clock,
	input  wire        rstN,
	input  wire        advance,
	input  wire [31:0] a,
	input  wire [31:0] b,
	input  wire        signedOp,
	output logic [63:0] product
);

	logic signed [32:0] opA;	// One extra bit for sign or zero extension
	logic signed [32:0] opB;
	logic signed [65:0] fullProd;
	logic [mulLatency-1:0][63:0] stage;	// Stage 0 takes the raw product

	// Extend both operands so one signed multiply covers both variants
	assign opA = {signedOp & a[31], a};
	assign opB = {signedOp & b[31], b};
	assign fullProd = opA * opB;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			stage <= '0;
		end else if (advance) begin
			stage[0] <= fullProd[63:0];	// Low 64 bits exact for both variants
			for (int i = 1; i < mulLatency; i++) begin
				stage[i] <= stage[i-1];	// One product per stage
			end
		end
	end

	assign product = stage[mulLatency-1];

endmodule

`default_nettype wire

// File: src/exPkg.sv
// Execute op encodings; sr bit 0 is T and bit 1 is carry, only 6-bit register ids are modelled
`default_nettype none

package exPkg;

	// Micro-op codes
	typedef enum logic [3:0] {
		cmdNop   = 4'd0,
		cmdAdd   = 4'd1,
		cmdSub   = 4'd2,
		cmdAnd   = 4'd3,
		cmdOr    = 4'd4,
		cmdXor   = 4'd5,
		cmdCmpEq = 4'd6,
		cmdCmpGt = 4'd7,	// Signed compare
		cmdMul   = 4'd8,
		cmdLoad  = 4'd9,
		cmdStore = 4'd10
	} uCmd_t;

	// Predicate, tested against T in EX2
	typedef enum logic [1:0] {
		predAlways  = 2'd0,
		predNever   = 2'd1,
		predIfTrue  = 2'd2,
		predIfFalse = 2'd3
	} pred_t;

	// Multiply variants
	typedef enum logic [1:0] {
		mulLowS  = 2'd0,	// Low half to rd, sign-extended
		mulLowU  = 2'd1,	// Low half to rd, zero-extended
		mulWideS = 2'd2,	// Full product to DLR/DHR, DHR sign-extended
		mulWideU = 2'd3	// Full product to DLR/DHR, zero-extended
	} mulMode_t;

	// Writeback source select, driven by exCtrl
	localparam logic [1:0] wbCmp  = 2'd0;	// T only, no rd write
	localparam logic [1:0] wbAlu  = 2'd1;	// ALU value and carry
	localparam logic [1:0] wbMul  = 2'd2;	// Product, routed by mulMode
	localparam logic [1:0] wbLoad = 2'd3;	// Load data

	typedef struct packed {
		logic        valid;
		uCmd_t       cmd;
		pred_t       pred;
		mulMode_t    mulMode;
		logic [5:0]  rd;	// Destination id
		logic [63:0] srcA;	// ALU A / base
		logic [63:0] srcB;	// ALU B / index
		logic [63:0] srcC;	// Store data
	} exUop_t;

	typedef struct packed {
		logic        valid;
		logic [5:0]  rd;
		logic [63:0] value;
	} exWb_t;

	typedef struct packed {
		logic [63:0] value;
		logic        carry;
		logic        tFlag;
	} aluRes_t;

endpackage

`default_nettype wire

// File: src/exStageTop.sv
// EX1/EX2 execute pipe; issue must stay stable while exHold is high, carry-in chaining is not supported
`timescale 1ns/100ps
`default_nettype none

module exStageTop
	import exPkg::*, memPkg::*;
#(
	parameter int mulLatency = 3
) (
	input  wire        clock,
	input  wire        rstN,
	input  wire exUop_t issue,
	input  wire        flush,
	output logic       exHold,
	output exWb_t      wb,
	output logic [1:0] sr,
	output logic [63:0] dlr,
	output logic [63:0] dhr,
	output memReq_t    memReq,
	input  wire memResp_t memResp,
	output logic       fault
);

	exUop_t      ex1Op;
	exUop_t      ex2Op;
	logic [31:0] ex2Addr;	// Registered address adder
	aluRes_t     ex1Alu;
	aluRes_t     ex2Alu;
	logic        opEnable;
	logic [1:0]  wbSel;
	logic [63:0] product;
	logic [63:0] loadData;
	logic        mulAdvance;
	logic        memFaulted;
	logic        hasResult;
	logic        retire;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			ex1Op.valid <= 1'b0;
			ex2Op.valid <= 1'b0;
		end else if (!exHold) begin
			ex1Op       <= issue;
			ex2Op       <= ex1Op;
			ex2Op.valid <= ex1Op.valid && !flush;	// Flush kills the EX1 op
			ex2Addr     <= ex1Op.srcA[31:0] + ex1Op.srcB[31:0];
			ex2Alu      <= ex1Alu;
		end else if (flush) begin
			ex1Op.valid <= 1'b0;	// Killed while waiting
		end
	end

	// Keep the multiplier moving while a MUL waits in EX2
	assign mulAdvance = !exHold || (ex2Op.valid && ex2Op.cmd == cmdMul);
	assign memFaulted = memReq.valid && memResp.status == memFault;
	assign hasResult  = !(ex2Op.cmd inside {cmdNop, cmdStore}) && !memFaulted;
	assign retire     = opEnable && !exHold && hasResult;

	exCtrl #(.mulLatency(mulLatency)) i_exCtrl (
		.clock(clock), .rstN(rstN), .ex2Op(ex2Op), .tBit(sr[0]),
		.memStatus(memResp.status), .opEnable(opEnable), .wbSel(wbSel),
		.exHold(exHold), .fault(fault)
	);

	exAlu i_exAlu (
		.a(ex1Op.srcA), .b(ex1Op.srcB), .cmd(ex1Op.cmd),
		.carryIn(1'b0), .res(ex1Alu)	// No add-with-carry op issued
	);

	exMul #(.mulLatency(mulLatency)) i_exMul (
		.clock(clock), .rstN(rstN), .advance(mulAdvance),
		.a(ex1Op.srcA[31:0]), .b(ex1Op.srcB[31:0]),
		.signedOp(ex1Op.mulMode inside {mulLowS, mulWideS}), .product(product)
	);

	exMemPort i_exMemPort (
		.clock(clock), .rstN(rstN), .ex2Op(ex2Op), .opEnable(opEnable),
		.addr(ex2Addr), .memReq(memReq), .memResp(memResp), .loadData(loadData)
	);

	exWriteback i_exWriteback (
		.clock(clock), .rstN(rstN), .retire(retire), .wbSel(wbSel),
		.rd(ex2Op.rd), .aluRes(ex2Alu), .product(product), .mulMode(ex2Op.mulMode),
		.loadData(loadData), .wb(wb), .sr(sr), .dlr(dlr), .dhr(dhr)
	);

endmodule

`default_nettype wire

// File: src/exWriteback.sv
// EX2 result registers; retire must be high only for ops with an effect, wb.valid is a one-cycle pulse
`timescale 1ns/100ps
`default_nettype none

module exWriteback
	import exPkg::*;
(
	input  wire        clock,
	input  wire        rstN,
	input  wire        retire,
	input  wire [1:0]  wbSel,
	input  wire [5:0]  rd,
	input  wire aluRes_t aluRes,
	input  wire [63:0] product,
	input  wire mulMode_t mulMode,
	input  wire [63:0] loadData,
	output exWb_t      wb,
	output logic [1:0] sr,	// Bit 0 T, bit 1 carry
	output logic [63:0] dlr,
	output logic [63:0] dhr
);

	logic        writesRd;
	logic [63:0] nextValue;
	logic        wbValid;
	logic [5:0]  wbRd;
	logic [63:0] wbValue;
	logic        loadSel;	// Last rd write came from memory

	always_comb begin
		writesRd  = 1'b0;
		nextValue = aluRes.value;
		case (wbSel)
			wbAlu: writesRd = 1'b1;
			wbMul: begin
				writesRd  = !mulMode[1];	// Wide modes go to DLR/DHR
				nextValue = {{32{product[31] & (mulMode == mulLowS)}}, product[31:0]};
			end
			wbLoad: writesRd = 1'b1;
			default: writesRd = 1'b0;	// Compare, T only
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			loadSel <= 1'b0;
			sr      <= '0;
			dlr     <= '0;
			dhr     <= '0;
		end else begin
			wbValid <= retire && writesRd;
			if (retire) begin
				if (writesRd) begin
					loadSel <= wbSel == wbLoad;
				end
				case (wbSel)
					wbCmp: sr[0] <= aluRes.tFlag;
					wbAlu: sr[1] <= aluRes.carry;	// Logic ops clear it
					wbMul: begin
						if (mulMode[1]) begin
							dlr <= {32'd0, product[31:0]};
							dhr <= {{32{product[63] & (mulMode == mulWideS)}}, product[63:32]};
						end
					end
					default: sr <= sr;	// Loads leave flags alone
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (retire && writesRd) begin
			wbRd    <= rd;
			wbValue <= nextValue;
		end
	end

	// Load data is registered in the memory port on the same edge
	assign wb = '{valid: wbValid, rd: wbRd, value: loadSel ? loadData : wbValue};

endmodule

`default_nettype wire

// File: src/memPkg.sv
// Data memory request and status types; 32-bit byte address, one 64-bit word per access
`default_nettype none

package memPkg;

	// Status bit 1 set means not done, bit 0 set with it means failed
	typedef enum logic [1:0] {
		memOk    = 2'b00,	// Done, data valid
		memHold  = 2'b10,	// Still busy
		memFault = 2'b11	// Access failed
	} memStatus_t;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [63:0] data;	// Store data
	} memReq_t;

	typedef struct packed {
		memStatus_t  status;
		logic [63:0] data;	// Load data, valid on memOk
	} memResp_t;

endpackage

`default_nettype wire
